// ==== common/filter_cond_defines.svh ====
// Width, FIFO depth and threshold macros, plus packet field positions
`ifndef FILTER_COND_DEFINES_SVH
`define FILTER_COND_DEFINES_SVH

`define FC_DATA_W      32
`define FC_ROUTE_W     4
`define FC_FIFO_DEPTH  16
`define FC_PROG_THRESH 8

// Packed packet: data, route_to, seq_src, seq_done, is_control
`define FC_PKT_W (`FC_DATA_W + 2 * `FC_ROUTE_W + 2)

// Field positions inside the packed packet
`define FC_IS_CTRL_BIT   0
`define FC_SEQ_DONE_BIT  1
`define FC_SEQ_SRC_LSB   2
`define FC_ROUTE_TO_LSB  (`FC_SEQ_SRC_LSB + `FC_ROUTE_W)
`define FC_DATA_LSB      (`FC_ROUTE_TO_LSB + `FC_ROUTE_W)

`endif

// ==== common/filter_cond_pkg.sv ====
// Filter-condition types: data, route and packet vectors, operator and run state enums
`include "filter_cond_defines.svh"

package filter_cond_pkg;

    // ---------------------------------------------------------
    // Vector types
    // ---------------------------------------------------------
    // Packet data word
    typedef logic [`FC_DATA_W-1:0] fc_data_t;

    // Destination or source id
    typedef logic [`FC_ROUTE_W-1:0] fc_route_t;

    // Whole packet as it sits in a FIFO
    typedef logic [`FC_PKT_W-1:0] fc_packet_t;

    // ---------------------------------------------------------
    // Enums
    // ---------------------------------------------------------
    // Compare operator, data against configured value
    typedef enum logic [1:0] {
        FC_OP_EQ = 2'd0,
        FC_OP_NE = 2'd1,
        FC_OP_LT = 2'd2,
        FC_OP_GT = 2'd3
    } fc_op_e;

    // Run sequence
    typedef enum logic [2:0] {
        FC_RESET      = 3'd0,
        FC_IDLE       = 3'd1,
        FC_SETUP_REQ  = 3'd2,
        FC_SETUP_WAIT = 3'd3,
        FC_BUSY       = 3'd4,
        FC_DRAIN      = 3'd5,
        FC_DONE       = 3'd6
    } fc_state_e;

endpackage : filter_cond_pkg

// ==== rtl/packet_fifo.sv ====
// Synchronous FIFO with registered read data, valid, empty, full and prog_full
`timescale 1ns/1ns
`include "filter_cond_defines.svh"

module packet_fifo #(
    parameter int DEPTH       = `FC_FIFO_DEPTH,
    parameter int WIDTH       = `FC_PKT_W,
    parameter int PROG_THRESH = `FC_PROG_THRESH
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             valid,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Flags straight off the count
    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign prog_full = (count >= CNT_W'(PROG_THRESH));

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= rd_en;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and read data
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
        if (rd_en) begin
            dout <= mem[rd_ptr];
        end
    end

    assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(wr_en && full) && !(rd_en && empty))
        else $error("packet_fifo overflow or underflow");

endmodule : packet_fifo

// ==== filter_cond/filter_cond_fsm.sv ====
// Run state machine: setup request, config wait, busy, drain and done
`timescale 1ns/1ns

module filter_cond_fsm
    import filter_cond_pkg::*;
(
    input  logic ap_clk,
    input  logic areset_generator,
    input  logic start,
    input  logic config_valid,
    input  logic seq_end_seen,
    input  logic pipe_empty,
    input  logic fifos_empty,
    output logic config_req,
    output logic load_config,
    output logic clear_config,
    output logic run_active,
    output logic done
);

    fc_state_e current_state;
    fc_state_e next_state;

    // ---------------------------------------------------------
    // State register
    // ---------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            current_state <= FC_RESET;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            FC_RESET: begin
                next_state = FC_IDLE;
            end
            FC_IDLE: begin
                if (start) begin
                    next_state = FC_SETUP_REQ;
                end
            end
            FC_SETUP_REQ: begin
                next_state = FC_SETUP_WAIT;
            end
            FC_SETUP_WAIT: begin
                if (config_valid) begin
                    next_state = FC_BUSY;
                end
            end
            FC_BUSY: begin
                // Sequence end closes the input side of the run
                if (seq_end_seen) begin
                    next_state = FC_DRAIN;
                end
            end
            FC_DRAIN: begin
                if (pipe_empty && fifos_empty) begin
                    next_state = FC_DONE;
                end
            end
            FC_DONE: begin
                next_state = FC_IDLE;
            end
            default: begin
                next_state = FC_RESET;
            end
        endcase
    end

    // ---------------------------------------------------------
    // Registered outputs
    // ---------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            config_req   <= 1'b0;
            load_config  <= 1'b0;
            clear_config <= 1'b0;
            run_active   <= 1'b0;
            done         <= 1'b0;
        end else begin
            // One cycle after entering setup request
            config_req   <= (current_state == FC_SETUP_REQ);
            // High for the whole wait, the last capture is the config_valid cycle
            load_config  <= (next_state == FC_SETUP_WAIT);
            run_active   <= (next_state == FC_BUSY) || (next_state == FC_DRAIN);
            clear_config <= (next_state == FC_DONE);
            done         <= (next_state == FC_DONE);
        end
    end

    assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(done && config_req))
        else $error("done and config_req high together");

endmodule : filter_cond_fsm

// ==== filter_cond/filter_cond_pipeline.sv ====
// Three-stage compare, route and split pipeline with input pop gating
`timescale 1ns/1ns
`include "filter_cond_defines.svh"

module filter_cond_pipeline
    import filter_cond_pkg::*;
(
    input  logic       ap_clk,
    input  logic       areset_generator,
    input  logic       load_config,
    input  logic       clear_config,
    input  logic       run_active,
    input  fc_op_e     cfg_op,
    input  fc_data_t   cfg_value,
    input  logic       cfg_invert,
    input  logic       cfg_conditional,
    input  fc_route_t  cfg_route_if,
    input  fc_route_t  cfg_route_else,
    input  fc_packet_t in_pkt,
    input  logic       in_pkt_valid,
    input  logic       in_empty,
    input  logic       engine_prog_full,
    input  logic       control_prog_full,
    output logic       in_pop,
    output logic       engine_wr,
    output logic       control_wr,
    output fc_packet_t out_pkt,
    output logic       seq_end_seen,
    output logic       pipe_empty
);

    // Held configuration
    fc_op_e    op_q;
    fc_data_t  value_q;
    logic      invert_q;
    logic      conditional_q;
    fc_route_t route_if_q;
    fc_route_t route_else_q;

    // Stage registers
    logic       s1_valid;
    fc_packet_t s1_pkt;
    logic       s2_valid;
    fc_packet_t s2_pkt;
    logic       s2_pass;

    logic      op_result;
    fc_data_t  s1_data;
    logic      s2_seq_done;
    fc_route_t s2_route_to;
    fc_route_t s2_seq_src;
    fc_route_t keep_route;

    // ---------------------------------------------------------
    // Configuration hold
    // ---------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator || clear_config) begin
            op_q          <= FC_OP_EQ;
            value_q       <= '0;
            invert_q      <= 1'b0;
            conditional_q <= 1'b0;
            route_if_q    <= '0;
            route_else_q  <= '0;
        end else if (load_config) begin
            op_q          <= cfg_op;
            value_q       <= cfg_value;
            invert_q      <= cfg_invert;
            conditional_q <= cfg_conditional;
            route_if_q    <= cfg_route_if;
            route_else_q  <= cfg_route_else;
        end
    end

    // Stall on either output nearing full so the in-flight packets still fit
    assign in_pop = run_active && !in_empty && !engine_prog_full && !control_prog_full;

    // ---------------------------------------------------------
    // Stage 1 and 2
    // ---------------------------------------------------------
    assign s1_data = s1_pkt[`FC_DATA_LSB +: `FC_DATA_W];

    always_comb begin
        case (op_q)
            FC_OP_EQ: op_result = (s1_data == value_q);
            FC_OP_NE: op_result = (s1_data != value_q);
            FC_OP_LT: op_result = (s1_data < value_q);
            FC_OP_GT: op_result = (s1_data > value_q);
            default:  op_result = 1'b0;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= in_pkt_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        s1_pkt  <= in_pkt;
        s2_pkt  <= s1_pkt;
        s2_pass <= op_result ^ invert_q;
    end

    // ---------------------------------------------------------
    // Stage 3 keep, route and split
    // ---------------------------------------------------------
    assign s2_seq_done = s2_pkt[`FC_SEQ_DONE_BIT];
    assign s2_route_to = s2_pkt[`FC_ROUTE_TO_LSB +: `FC_ROUTE_W];
    assign s2_seq_src  = s2_pkt[`FC_SEQ_SRC_LSB +: `FC_ROUTE_W];

    always_comb begin
        keep_route = s2_route_to;
        if (conditional_q) begin
            keep_route = s2_pass ? route_if_q : route_else_q;
        end
    end

    // Sequence end goes back to its source as a control packet
    always_comb begin
        out_pkt = s2_pkt;
        if (s2_seq_done) begin
            out_pkt[`FC_ROUTE_TO_LSB +: `FC_ROUTE_W] = s2_seq_src;
            out_pkt[`FC_IS_CTRL_BIT]                 = 1'b1;
        end else begin
            out_pkt[`FC_ROUTE_TO_LSB +: `FC_ROUTE_W] = keep_route;
            out_pkt[`FC_IS_CTRL_BIT]                 = 1'b0;
        end
    end

    assign control_wr   = s2_valid && s2_seq_done;
    assign engine_wr    = s2_valid && !s2_seq_done && (conditional_q || s2_pass);
    assign seq_end_seen = control_wr;
    assign pipe_empty   = !in_pkt_valid && !s1_valid && !s2_valid;

    assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(engine_wr && control_wr))
        else $error("engine and control write in the same cycle");

endmodule : filter_cond_pipeline

// ==== filter_cond/filter_cond_top.sv ====
// Filter-condition engine top: input, engine and control FIFOs, run FSM and pipeline
`timescale 1ns/1ns
`include "filter_cond_defines.svh"

module filter_cond_top
    import filter_cond_pkg::*;
(
    input  logic      ap_clk,
    input  logic      areset_generator,
    input  logic      start,
    input  logic      config_valid,
    input  fc_op_e    cfg_op,
    input  fc_data_t  cfg_value,
    input  logic      cfg_invert,
    input  logic      cfg_conditional,
    input  fc_route_t cfg_route_if,
    input  fc_route_t cfg_route_else,
    input  logic      in_valid,
    input  fc_data_t  in_data,
    input  fc_route_t in_route_to,
    input  fc_route_t in_seq_src,
    input  logic      in_seq_done,
    input  logic      engine_rd_en,
    input  logic      control_rd_en,
    output logic      config_req,
    output logic      in_full,
    output logic      engine_valid,
    output fc_data_t  engine_data,
    output fc_route_t engine_route_to,
    output logic      control_valid,
    output fc_route_t control_route_to,
    output fc_data_t  control_data,
    output logic      done
);

    fc_packet_t in_din;
    fc_packet_t in_dout;
    fc_packet_t out_pkt;
    fc_packet_t engine_dout;
    fc_packet_t control_dout;

    logic in_pop, in_pkt_valid, in_empty;
    logic engine_wr, engine_pop, engine_empty, engine_prog_full;
    logic control_wr, control_pop, control_empty, control_prog_full;
    logic load_config, clear_config, run_active;
    logic seq_end_seen, pipe_empty, fifos_empty;

    // ---------------------------------------------------------
    // Packing and unpacking
    // ---------------------------------------------------------
    assign in_din = {in_data, in_route_to, in_seq_src, in_seq_done, 1'b0};

    assign engine_data      = engine_dout[`FC_DATA_LSB +: `FC_DATA_W];
    assign engine_route_to  = engine_dout[`FC_ROUTE_TO_LSB +: `FC_ROUTE_W];
    assign control_data     = control_dout[`FC_DATA_LSB +: `FC_DATA_W];
    assign control_route_to = control_dout[`FC_ROUTE_TO_LSB +: `FC_ROUTE_W];

    // External pops only while data is there
    assign engine_pop  = engine_rd_en && !engine_empty;
    assign control_pop = control_rd_en && !control_empty;
    assign fifos_empty = in_empty && engine_empty && control_empty;

    // ---------------------------------------------------------
    // FIFOs
    // ---------------------------------------------------------
    packet_fifo #(
        .DEPTH(`FC_FIFO_DEPTH), .WIDTH(`FC_PKT_W), .PROG_THRESH(`FC_PROG_THRESH)
    ) u_in_fifo (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .wr_en(in_valid), .din(in_din), .rd_en(in_pop),
        .dout(in_dout), .valid(in_pkt_valid), .empty(in_empty),
        .full(in_full), .prog_full()
    );

    packet_fifo #(
        .DEPTH(`FC_FIFO_DEPTH), .WIDTH(`FC_PKT_W), .PROG_THRESH(`FC_PROG_THRESH)
    ) u_engine_fifo (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .wr_en(engine_wr), .din(out_pkt), .rd_en(engine_pop),
        .dout(engine_dout), .valid(engine_valid), .empty(engine_empty),
        .full(), .prog_full(engine_prog_full)
    );

    packet_fifo #(
        .DEPTH(`FC_FIFO_DEPTH), .WIDTH(`FC_PKT_W), .PROG_THRESH(`FC_PROG_THRESH)
    ) u_control_fifo (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .wr_en(control_wr), .din(out_pkt), .rd_en(control_pop),
        .dout(control_dout), .valid(control_valid), .empty(control_empty),
        .full(), .prog_full(control_prog_full)
    );

    // ---------------------------------------------------------
    // Control and datapath
    // ---------------------------------------------------------
    filter_cond_fsm u_fsm (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .start(start), .config_valid(config_valid), .seq_end_seen(seq_end_seen),
        .pipe_empty(pipe_empty), .fifos_empty(fifos_empty),
        .config_req(config_req), .load_config(load_config),
        .clear_config(clear_config), .run_active(run_active), .done(done)
    );

    filter_cond_pipeline u_pipeline (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .load_config(load_config), .clear_config(clear_config), .run_active(run_active),
        .cfg_op(cfg_op), .cfg_value(cfg_value), .cfg_invert(cfg_invert),
        .cfg_conditional(cfg_conditional), .cfg_route_if(cfg_route_if),
        .cfg_route_else(cfg_route_else),
        .in_pkt(in_dout), .in_pkt_valid(in_pkt_valid), .in_empty(in_empty),
        .engine_prog_full(engine_prog_full), .control_prog_full(control_prog_full),
        .in_pop(in_pop), .engine_wr(engine_wr), .control_wr(control_wr),
        .out_pkt(out_pkt), .seq_end_seen(seq_end_seen), .pipe_empty(pipe_empty)
    );

endmodule : filter_cond_top

// ==== verification/tb_clock_gen.sv ====
// Testbench clock and reset generator, 40 ns period and 10-cycle reset
`timescale 1ns/1ns

module tb_clock_gen (
    output logic ap_clk,
    output logic areset_generator
);

    initial begin
        ap_clk = 1'b0;
        forever #20 ap_clk = ~ap_clk;
    end

    // Reset released on a rising edge
    initial begin
        areset_generator = 1'b1;
        repeat (10) @(posedge ap_clk);
        areset_generator <= 1'b0;
    end

endmodule : tb_clock_gen

// ==== verification/tb_filter_cond.sv ====
// Filter-condition testbench: LCG stimulus, expected-packet queues, output checks, timeout
`timescale 1ns/1ns

module tb_filter_cond
    import filter_cond_pkg::*;
;

    localparam int MAX_CYCLES = 3000;

    logic      ap_clk, areset_generator;
    logic      start, config_valid, cfg_invert, cfg_conditional;
    fc_op_e    cfg_op;
    fc_data_t  cfg_value;
    fc_route_t cfg_route_if, cfg_route_else;
    logic      in_valid, in_seq_done, engine_rd_en, control_rd_en;
    fc_data_t  in_data;
    fc_route_t in_route_to, in_seq_src;
    logic      config_req, in_full, engine_valid, control_valid, done;
    fc_data_t  engine_data, control_data;
    fc_route_t engine_route_to, control_route_to;

    fc_data_t  eng_data_q[$];
    fc_route_t eng_route_q[$];
    fc_data_t  ctl_data_q[$];
    fc_route_t ctl_route_q[$];
    logic [31:0] lcg_state;
    int        cycle_count;
    int        done_count;
    logic      saw_in_full;

    tb_clock_gen u_clock_gen (.ap_clk(ap_clk), .areset_generator(areset_generator));

    filter_cond_top DUT (.*);

    // ---------------------------------------------------------
    // Helpers
    // ---------------------------------------------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Operator result, then optional inversion
    function automatic logic compare_passes(fc_op_e op, fc_data_t d, fc_data_t v, logic inv);
        logic r;
        case (op)
            FC_OP_EQ: r = (d == v);
            FC_OP_NE: r = (d != v);
            FC_OP_LT: r = (d < v);
            default:  r = (d > v);
        endcase
        return r ^ inv;
    endfunction

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        report_fail($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, exp, got));
    endtask

    // ---------------------------------------------------------
    // Monitors
    // ---------------------------------------------------------
    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            report_fail("timeout: run did not finish within the cycle limit");
        end
    end

    always @(posedge ap_clk) begin
        if (!areset_generator && done) done_count <= done_count + 1;
        if (!areset_generator && in_full) saw_in_full <= 1'b1;
    end

    always @(posedge ap_clk) begin
        if (!areset_generator && engine_valid) begin
            if (eng_data_q.size() == 0) begin
                report_fail("engine output appeared with no packet expected");
            end else begin
                assert (engine_data == eng_data_q[0])
                    else report_mismatch("engine_data", eng_data_q[0], engine_data);
                assert (engine_route_to == eng_route_q[0])
                    else report_mismatch("engine_route_to", 32'(eng_route_q[0]),
                                         32'(engine_route_to));
                void'(eng_data_q.pop_front());
                void'(eng_route_q.pop_front());
            end
        end
    end

    always @(posedge ap_clk) begin
        if (!areset_generator && control_valid) begin
            if (ctl_data_q.size() == 0) begin
                report_fail("control output appeared with no packet expected");
            end else begin
                assert (control_data == ctl_data_q[0])
                    else report_mismatch("control_data", ctl_data_q[0], control_data);
                assert (control_route_to == ctl_route_q[0])
                    else report_mismatch("control_route_to", 32'(ctl_route_q[0]),
                                         32'(control_route_to));
                void'(ctl_data_q.pop_front());
                void'(ctl_route_q.pop_front());
            end
        end
    end

    // ---------------------------------------------------------
    // Stimulus
    // ---------------------------------------------------------
    // One write, then an idle cycle so in_full reflects it
    task automatic send_packet(input fc_data_t d, input fc_route_t r,
                               input fc_route_t src, input logic last);
        while (in_full) @(posedge ap_clk);
        in_valid    <= 1'b1;
        in_data     <= d;
        in_route_to <= r;
        in_seq_src  <= src;
        in_seq_done <= last;
        @(posedge ap_clk);
        in_valid    <= 1'b0;
        @(posedge ap_clk);
    endtask

    task automatic run_test(input fc_op_e op, input fc_data_t value, input logic inv,
                            input logic cond, input int n, input logic hold, input int run_no);
        fc_data_t  d;
        fc_route_t r;
        fc_route_t src;
        logic      pass;
        logic      last;
        start <= 1'b1;
        @(posedge ap_clk);
        start <= 1'b0;
        assert (!config_req) else report_fail("config_req high one cycle after start");
        @(posedge ap_clk);
        assert (!config_req) else report_fail("config_req high too early");
        @(posedge ap_clk);
        assert (config_req) else report_fail("config_req not high 2 cycles after start");
        config_valid    <= 1'b1;
        cfg_op          <= op;
        cfg_value       <= value;
        cfg_invert      <= inv;
        cfg_conditional <= cond;
        cfg_route_if    <= 4'hA;
        cfg_route_else  <= 4'h5;
        @(posedge ap_clk);
        config_valid <= 1'b0;
        @(posedge ap_clk);
        fork
            begin
                for (int i = 0; i < n; i++) begin
                    d    = (next_rand() % 4 == 0) ? value : next_rand();
                    r    = fc_route_t'(next_rand());
                    src  = fc_route_t'(next_rand());
                    last = (i == n - 1);
                    pass = compare_passes(op, d, value, inv);
                    if (last) begin
                        ctl_data_q.push_back(d);
                        ctl_route_q.push_back(src);
                    end else if (cond) begin
                        eng_data_q.push_back(d);
                        eng_route_q.push_back(pass ? 4'hA : 4'h5);
                    end else if (pass) begin
                        eng_data_q.push_back(d);
                        eng_route_q.push_back(r);
                    end
                    send_packet(d, r, src, last);
                end
            end
            begin
                if (hold) begin
                    engine_rd_en <= 1'b0;
                    repeat (100) @(posedge ap_clk);
                    engine_rd_en <= 1'b1;
                end
            end
        join
        while (!done) @(posedge ap_clk);
        repeat (3) @(posedge ap_clk);
        assert (eng_data_q.size() == 0 && ctl_data_q.size() == 0)
            else report_fail("run finished with expected packets still missing");
        assert (done_count == run_no)
            else report_fail("done did not pulse exactly once for the run");
    endtask

    initial begin
        lcg_state       = 32'h85eb;
        cycle_count     = 0;
        done_count      = 0;
        saw_in_full     = 1'b0;
        start           <= 1'b0;
        config_valid    <= 1'b0;
        cfg_op          <= FC_OP_EQ;
        cfg_value       <= '0;
        cfg_invert      <= 1'b0;
        cfg_conditional <= 1'b0;
        cfg_route_if    <= '0;
        cfg_route_else  <= '0;
        in_valid        <= 1'b0;
        in_data         <= '0;
        in_route_to     <= '0;
        in_seq_src      <= '0;
        in_seq_done     <= 1'b0;
        engine_rd_en    <= 1'b1;
        control_rd_en   <= 1'b1;
        @(posedge ap_clk);
        while (areset_generator) @(posedge ap_clk);
        repeat (2) @(posedge ap_clk);
        assert (!config_req && !done && !in_full && !engine_valid && !control_valid)
            else report_fail("outputs not low after reset");

        run_test(FC_OP_EQ, 32'h1234_5678, 1'b0, 1'b0, 40, 1'b0, 1);
        run_test(FC_OP_NE, 32'h0BAD_F00D, 1'b1, 1'b0, 40, 1'b0, 2);
        run_test(FC_OP_LT, 32'h8000_0000, 1'b0, 1'b0, 40, 1'b0, 3);
        // Conditional routing forwards every data packet
        run_test(FC_OP_GT, 32'h8000_0000, 1'b1, 1'b1, 40, 1'b0, 4);
        // Most packets pass while the engine side is held back
        run_test(FC_OP_GT, 32'h0000_0000, 1'b0, 1'b0, 40, 1'b1, 5);

        if (!saw_in_full) begin
            report_fail("in_full never rose while the engine output was held");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule : tb_filter_cond

// ==== vlog.f ====
+incdir+common
common/filter_cond_pkg.sv
rtl/packet_fifo.sv
filter_cond/filter_cond_fsm.sv
filter_cond/filter_cond_pipeline.sv
filter_cond/filter_cond_top.sv
verification/tb_clock_gen.sv
verification/tb_filter_cond.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f vlog.f --top-module tb_filter_cond -Mdir obj_dir
	./obj_dir/Vtb_filter_cond | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
